//--- verilog/game_pkg.sv
// Shared types for the penalty-shootout game core.
// Game state and mode encodings, link message kinds and the 8-bit link message.
// Directions use 0 = left, 1 = centre, 2 = right; code 3 is read as centre.
package game_pkg;

    typedef enum logic [2:0] {
        START,
        KEEPER,
        SHOOTER,
        WINNER,
        LOSER
    } g_state;

    typedef enum logic {
        SOLO,
        MULTI
    } g_mode;

    typedef enum logic [1:0] {
        HELLO,
        START_MSG,
        CHOICE
    } msg_kind;

    typedef struct packed {
        msg_kind    kind;
        logic       role;       // 1 means the receiver shoots.
        logic [4:0] unused;
    } ctrl_msg;

    typedef struct packed {
        msg_kind    kind;
        logic [1:0] dir;
        logic [2:0] round_num;
        logic       unused;
    } choice_msg;

    // One byte on the link, read by its kind field.
    typedef union packed {
        ctrl_msg   ctrl;
        choice_msg choice;
    } link_msg;

    // Folds code 3 onto centre.
    function automatic logic [1:0] norm_dir(input logic [1:0] dir);
        return (dir == 2'd3) ? 2'd1 : dir;
    endfunction

endpackage

//--- verilog/click_sync.sv
// Mouse button synchronizer.
// Brings both button levels into the clock domain and emits one pulse per press.
module click_sync (
    input  logic clk,
    input  logic rst,
    input  logic left_btn,
    input  logic right_btn,
    output logic left_clicked,
    output logic right_clicked
);

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= 2'b00;
            btn_sync <= 2'b00;
            btn_prev <= 2'b00;
        end else begin
            btn_meta <= {right_btn, left_btn};
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign left_clicked  = btn_sync[0] & ~btn_prev[0]; // Rising edge.
    assign right_clicked = btn_sync[1] & ~btn_prev[1];

endmodule

//--- verilog/game_state_sel.sv
// Game state and mode controller.
// Moves between start, keeper, shooter and result screens from clicks,
// link events and the judge's verdict. Mode is only sampled in START.
module game_state_sel (
    input  logic            clk,
    input  logic            rst,
    input  logic            left_clicked,
    input  logic            right_clicked,
    input  logic            solo_enable,
    input  logic            connect_corrected,
    input  logic            enemy_shooter,
    input  logic            match_end,
    input  logic            match_result,
    input  logic            game_starts,
    output game_pkg::g_state game_state,
    output game_pkg::g_mode  game_mode
);

    game_pkg::g_state game_state_nxt;
    game_pkg::g_mode  game_mode_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= game_pkg::START;
            game_mode  <= game_pkg::MULTI;
        end else begin
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
        end
    end

    // Switch is ignored once a match is running.
    always_comb begin
        if (game_state == game_pkg::START) begin
            game_mode_nxt = solo_enable ? game_pkg::SOLO : game_pkg::MULTI;
        end else begin
            game_mode_nxt = game_mode;
        end
    end

    always_comb begin
        game_state_nxt = game_state;
        case (game_state)
            game_pkg::START: begin
                if (game_mode == game_pkg::SOLO) begin
                    if (left_clicked) begin
                        game_state_nxt = game_pkg::KEEPER; // Solo player always keeps.
                    end
                end else if (game_starts && connect_corrected) begin
                    if (!enemy_shooter) begin
                        game_state_nxt = game_pkg::KEEPER;
                    end else begin
                        game_state_nxt = game_pkg::SHOOTER;
                    end
                end
            end
            game_pkg::KEEPER,
            game_pkg::SHOOTER: begin
                if (match_end) begin
                    game_state_nxt = match_result ? game_pkg::WINNER : game_pkg::LOSER;
                end
            end
            game_pkg::WINNER,
            game_pkg::LOSER: begin
                if (right_clicked) begin
                    game_state_nxt = game_pkg::START;
                end
            end
            default: begin
                game_state_nxt = game_pkg::START;
            end
        endcase

        // Losing the peer ends any multi game.
        if (game_mode == game_pkg::MULTI && !connect_corrected) begin
            game_state_nxt = game_pkg::START;
        end
    end

endmodule

//--- verilog/link_ctrl.sv
// Link controller for multi mode.
// Runs the hello exchange, starts a match on a click or a peer START_MSG,
// forwards peer choices to the judge and sends committed local choices.
module link_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             left_clicked,
    input  game_pkg::g_state game_state,
    input  game_pkg::g_mode  game_mode,
    input  logic             link_rx_valid,
    input  logic [7:0]       link_rx_data,
    input  logic             choice_commit,
    input  logic [1:0]       choice_dir,
    input  logic [2:0]       round_idx,
    output logic             connect_corrected,
    output logic             game_starts,
    output logic             enemy_shooter,
    output logic             peer_valid,
    output logic [1:0]       peer_dir,
    output logic             link_tx_valid,
    output logic [7:0]       link_tx_data
);

    game_pkg::link_msg rx_msg;
    game_pkg::link_msg tx_msg;
    logic              tx_send;
    logic              hello_sent;
    logic              hello_sent_nxt;
    logic              connected_nxt;
    logic              starts_nxt;
    logic              shooter_nxt;
    logic              peer_valid_nxt;
    logic [1:0]        peer_dir_nxt;
    logic              in_match;

    assign rx_msg   = link_rx_data;
    assign in_match = (game_state == game_pkg::KEEPER) || (game_state == game_pkg::SHOOTER);

    always_comb begin
        tx_msg         = '0;
        tx_send        = 1'b0;
        hello_sent_nxt = hello_sent;
        connected_nxt  = connect_corrected;
        starts_nxt     = 1'b0;
        shooter_nxt    = enemy_shooter;
        peer_valid_nxt = 1'b0;
        peer_dir_nxt   = peer_dir;

        if (game_mode == game_pkg::SOLO) begin
            connected_nxt  = 1'b0;
            hello_sent_nxt = 1'b0;
        end else if (game_state == game_pkg::START) begin
            if (link_rx_valid && rx_msg.ctrl.kind == game_pkg::HELLO && !connect_corrected) begin
                connected_nxt = 1'b1;
                if (!hello_sent) begin // Answer a peer that spoke first.
                    tx_send           = 1'b1;
                    tx_msg.ctrl.kind  = game_pkg::HELLO;
                    hello_sent_nxt    = 1'b1;
                end
            end else if (link_rx_valid && rx_msg.ctrl.kind == game_pkg::START_MSG &&
                         connect_corrected) begin
                starts_nxt  = 1'b1;
                shooter_nxt = rx_msg.ctrl.role;
            end else if (left_clicked) begin
                tx_send = 1'b1;
                if (connect_corrected) begin
                    tx_msg.ctrl.kind = game_pkg::START_MSG;
                    tx_msg.ctrl.role = 1'b1; // Peer shoots, we keep.
                    starts_nxt       = 1'b1;
                    shooter_nxt      = 1'b0;
                end else begin
                    tx_msg.ctrl.kind = game_pkg::HELLO;
                    hello_sent_nxt   = 1'b1;
                end
            end
        end else if (in_match) begin
            if (link_rx_valid && rx_msg.choice.kind == game_pkg::CHOICE) begin
                peer_valid_nxt = 1'b1;
                peer_dir_nxt   = rx_msg.choice.dir;
            end
            if (choice_commit) begin
                tx_send                 = 1'b1;
                tx_msg.choice.kind      = game_pkg::CHOICE;
                tx_msg.choice.dir       = choice_dir;
                tx_msg.choice.round_num = round_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            connect_corrected <= 1'b0;
            hello_sent        <= 1'b0;
            game_starts       <= 1'b0;
            enemy_shooter     <= 1'b0;
            peer_valid        <= 1'b0;
            link_tx_valid     <= 1'b0;
        end else begin
            connect_corrected <= connected_nxt;
            hello_sent        <= hello_sent_nxt;
            game_starts       <= starts_nxt;
            enemy_shooter     <= shooter_nxt;
            peer_valid        <= peer_valid_nxt;
            link_tx_valid     <= tx_send;
        end
    end

    always_ff @(posedge clk) begin
        peer_dir     <= peer_dir_nxt;
        link_tx_data <= tx_msg;
    end

endmodule

//--- verilog/solo_opponent.sv
// Pseudo-random shooter for solo mode.
// An 8-bit Fibonacci LFSR (x^8+x^6+x^5+x^4+1) that steps once per committed choice.
// The current low two bits give the opponent's direction for the open round.
module solo_opponent #(
    parameter logic [7:0] LFSR_SEED = 8'h5a
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       choice_commit,
    output logic [1:0] opp_dir
);

    logic [7:0] lfsr;
    logic       feedback;

    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else if (choice_commit) begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

    assign opp_dir = game_pkg::norm_dir(lfsr[1:0]); // Code 3 plays as centre.

endmodule

//--- verilog/match_judge.sv
// Round judge for one match.
// Records the player's aim on a click, takes the opponent's direction from the
// LFSR in solo mode or from the first peer CHOICE in multi mode, counts goals
// and pulses match_end with the result after the last round.
module match_judge #(
    parameter int ROUNDS = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             left_clicked,
    input  logic [1:0]       aim,
    input  game_pkg::g_state game_state,
    input  game_pkg::g_mode  game_mode,
    input  logic [1:0]       opp_dir,
    input  logic             peer_valid,
    input  logic [1:0]       peer_dir,
    output logic             choice_commit,
    output logic [1:0]       choice_dir,
    output logic [2:0]       round_idx,
    output logic             match_end,
    output logic             match_result,
    output logic [2:0]       score_goals
);

    localparam int CW   = $clog2(ROUNDS + 1);
    localparam int HALF = ROUNDS / 2;

    logic [CW-1:0] rounds_done;
    logic [1:0]    opp_dir_r;
    logic          player_have;
    logic          opp_have;
    logic          ending;     // Last round scored, verdict next cycle.
    logic          done;
    logic          in_match;
    logic          is_goal;

    assign in_match  = (game_state == game_pkg::KEEPER) || (game_state == game_pkg::SHOOTER);
    assign is_goal   = game_pkg::norm_dir(choice_dir) != game_pkg::norm_dir(opp_dir_r);
    assign round_idx = 3'(rounds_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            rounds_done   <= '0;
            score_goals   <= 3'd0;
            player_have   <= 1'b0;
            opp_have      <= 1'b0;
            ending        <= 1'b0;
            done          <= 1'b0;
            choice_commit <= 1'b0;
            match_end     <= 1'b0;
            match_result  <= 1'b0;
        end else begin
            choice_commit <= 1'b0;
            match_end     <= 1'b0;
            if (game_state == game_pkg::START) begin
                rounds_done <= '0;
                score_goals <= 3'd0;
                player_have <= 1'b0;
                opp_have    <= 1'b0;
                ending      <= 1'b0;
                done        <= 1'b0;
            end else if (in_match && !done) begin
                if (ending) begin
                    match_end <= 1'b1;
                    ending    <= 1'b0;
                    done      <= 1'b1;
                    if (game_state == game_pkg::KEEPER) begin
                        match_result <= (int'(score_goals) <= HALF);
                    end else begin
                        match_result <= (int'(score_goals) > HALF);
                    end
                end else if (player_have && opp_have) begin
                    score_goals <= score_goals + 3'(is_goal);
                    rounds_done <= rounds_done + 1'b1;
                    player_have <= 1'b0;
                    opp_have    <= 1'b0;
                    if (rounds_done == CW'(ROUNDS - 1)) begin
                        ending <= 1'b1;
                    end
                end else begin
                    if (left_clicked && !player_have) begin
                        player_have   <= 1'b1;
                        choice_commit <= 1'b1;
                        if (game_mode == game_pkg::SOLO) begin
                            opp_have  <= 1'b1; // LFSR value before this commit.
                        end
                    end
                    if (game_mode == game_pkg::MULTI && peer_valid && !opp_have) begin
                        opp_have <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (left_clicked && !player_have) begin
            choice_dir <= aim;
            if (game_mode == game_pkg::SOLO) begin
                opp_dir_r <= opp_dir;
            end
        end
        if (game_mode == game_pkg::MULTI && peer_valid && !opp_have) begin
            opp_dir_r <= peer_dir;
        end
    end

endmodule

//--- verilog/game_top.sv
// Top level of the game-flow core.
// Ties the click synchronizer, state controller, link controller, solo
// opponent and judge together. ROUNDS and LFSR_SEED are set here.
module game_top #(
    parameter int         ROUNDS    = 5,
    parameter logic [7:0] LFSR_SEED = 8'h5a
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             left_btn,
    input  logic             right_btn,
    input  logic             solo_enable,
    input  logic [1:0]       aim,
    input  logic             link_rx_valid,
    input  logic [7:0]       link_rx_data,
    output logic             link_tx_valid,
    output logic [7:0]       link_tx_data,
    output game_pkg::g_state game_state,
    output game_pkg::g_mode  game_mode,
    output logic [2:0]       score_goals
);

    logic       left_clicked;
    logic       right_clicked;
    logic       connect_corrected;
    logic       game_starts;
    logic       enemy_shooter;
    logic       peer_valid;
    logic [1:0] peer_dir;
    logic       match_end;
    logic       match_result;
    logic       choice_commit;
    logic [1:0] choice_dir;
    logic [2:0] round_idx;
    logic [1:0] opp_dir;

    click_sync u_click_sync (
        .clk           (clk),
        .rst           (rst),
        .left_btn      (left_btn),
        .right_btn     (right_btn),
        .left_clicked  (left_clicked),
        .right_clicked (right_clicked)
    );

    game_state_sel u_game_state_sel (
        .clk               (clk),
        .rst               (rst),
        .left_clicked      (left_clicked),
        .right_clicked     (right_clicked),
        .solo_enable       (solo_enable),
        .connect_corrected (connect_corrected),
        .enemy_shooter     (enemy_shooter),
        .match_end         (match_end),
        .match_result      (match_result),
        .game_starts       (game_starts),
        .game_state        (game_state),
        .game_mode         (game_mode)
    );

    link_ctrl u_link_ctrl (
        .clk               (clk),
        .rst               (rst),
        .left_clicked      (left_clicked),
        .game_state        (game_state),
        .game_mode         (game_mode),
        .link_rx_valid     (link_rx_valid),
        .link_rx_data      (link_rx_data),
        .choice_commit     (choice_commit),
        .choice_dir        (choice_dir),
        .round_idx         (round_idx),
        .connect_corrected (connect_corrected),
        .game_starts       (game_starts),
        .enemy_shooter     (enemy_shooter),
        .peer_valid        (peer_valid),
        .peer_dir          (peer_dir),
        .link_tx_valid     (link_tx_valid),
        .link_tx_data      (link_tx_data)
    );

    solo_opponent #(
        .LFSR_SEED (LFSR_SEED)
    ) u_solo_opponent (
        .clk           (clk),
        .rst           (rst),
        .choice_commit (choice_commit),
        .opp_dir       (opp_dir)
    );

    match_judge #(
        .ROUNDS (ROUNDS)
    ) u_match_judge (
        .clk           (clk),
        .rst           (rst),
        .left_clicked  (left_clicked),
        .aim           (aim),
        .game_state    (game_state),
        .game_mode     (game_mode),
        .opp_dir       (opp_dir),
        .peer_valid    (peer_valid),
        .peer_dir      (peer_dir),
        .choice_commit (choice_commit),
        .choice_dir    (choice_dir),
        .round_idx     (round_idx),
        .match_end     (match_end),
        .match_result  (match_result),
        .score_goals   (score_goals)
    );

endmodule

//--- test/game_tb.sv
// Self-checking testbench for the penalty-shootout game core.
// Acts as the mouse, the mode switch and the peer board, driven by
// test/game_stimulus.txt, and checks link bytes, state, mode and score.
module game_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int         ROUNDS     = 5;
    localparam logic [7:0] LFSR_SEED  = 8'h5a;
    localparam int         STIM_DEPTH = 128;
    localparam int         TIMEOUT    = 200; // Cycles per wait.

    logic             clk;
    logic             rst;
    logic             left_btn;
    logic             right_btn;
    logic             solo_enable;
    logic [1:0]       aim;
    logic             link_rx_valid;
    logic [7:0]       link_rx_data;
    logic             link_tx_valid;
    logic [7:0]       link_tx_data;
    game_pkg::g_state game_state;
    game_pkg::g_mode  game_mode;
    logic [2:0]       score_goals;

    logic [15:0] stim [0:STIM_DEPTH-1];
    logic [7:0]  tx_queue [$];
    logic [7:0]  lfsr_model;
    int          goals;
    int          round_num;

    game_top #(
        .ROUNDS    (ROUNDS),
        .LFSR_SEED (LFSR_SEED)
    ) DUT (
        .clk           (clk),
        .rst           (rst),
        .left_btn      (left_btn),
        .right_btn     (right_btn),
        .solo_enable   (solo_enable),
        .aim           (aim),
        .link_rx_valid (link_rx_valid),
        .link_rx_data  (link_rx_data),
        .link_tx_valid (link_tx_valid),
        .link_tx_data  (link_tx_data),
        .game_state    (game_state),
        .game_mode     (game_mode),
        .score_goals   (score_goals)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Every byte the board sends, in order.
    always @(posedge clk) begin
        if (!rst && link_tx_valid === 1'b1) begin
            tx_queue.push_back(link_tx_data);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first failure.");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    // Code 3 plays as centre on both sides.
    function automatic logic is_goal(input logic [1:0] shot, input logic [1:0] keep);
        logic [1:0] s;
        logic [1:0] k;
        s = (shot == 2'd3) ? 2'd1 : shot;
        k = (keep == 2'd3) ? 2'd1 : keep;
        return s != k;
    endfunction

    task automatic press_button(input logic right);
        @(posedge clk);
        if (right) begin
            right_btn <= 1'b1;
        end else begin
            left_btn <= 1'b1;
        end
        repeat (4) @(posedge clk);
        left_btn  <= 1'b0;
        right_btn <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic send_peer_byte(input logic [7:0] data);
        @(posedge clk);
        link_rx_valid <= 1'b1;
        link_rx_data  <= data;
        @(posedge clk);
        link_rx_valid <= 1'b0;
        link_rx_data  <= 8'h00;
        repeat (4) @(posedge clk);
    endtask

    task automatic expect_tx(input string name, input logic [7:0] expected);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (tx_queue.size() == 0 && waited < TIMEOUT);
        if (tx_queue.size() == 0) begin
            abort_run($sformatf("%s: the board sent no byte on the link.", name));
        end
        check_equal(name, expected, tx_queue.pop_front());
    endtask

    task automatic wait_state(input string name, input logic [7:0] expected);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (game_state !== expected && waited < TIMEOUT);
        check_equal(name, expected, game_state);
    endtask

    task automatic wait_mode(input string name, input logic [7:0] expected);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (game_mode !== expected && waited < TIMEOUT);
        check_equal(name, expected, game_mode);
    endtask

    task automatic stay_quiet(input string name, input int cycles);
        repeat (cycles) @(negedge clk);
        check_equal({name, " bytes sent"}, 0, tx_queue.size());
    endtask

    // One round; the LFSR model steps on every committed choice.
    task automatic play_round(input string name, input logic [1:0] aim_dir,
                              input logic solo, input logic [1:0] peer);
        logic [1:0] opp;
        @(posedge clk);
        aim <= aim_dir;
        press_button(1'b0);
        if (solo) begin
            opp = lfsr_model[1:0];
        end else begin
            expect_tx({name, " choice"}, {2'b10, aim_dir, 3'(round_num), 1'b0});
            send_peer_byte({2'b10, peer, 3'(round_num), 1'b0});
            opp = peer;
        end
        lfsr_model = {lfsr_model[6:0],
                      lfsr_model[7] ^ lfsr_model[5] ^ lfsr_model[4] ^ lfsr_model[3]};
        if (is_goal(aim_dir, opp)) begin
            goals++;
        end
        round_num++;
    endtask

    task automatic check_verdict(input string name, input logic shooter);
        int   waited;
        logic win;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (game_state != game_pkg::WINNER && game_state != game_pkg::LOSER &&
                   waited < TIMEOUT);
        win = shooter ? (goals > ROUNDS / 2) : (goals <= ROUNDS / 2);
        check_equal({name, " result"}, win ? game_pkg::WINNER : game_pkg::LOSER, game_state);
        check_equal({name, " goals"}, goals, score_goals);
        goals     = 0;
        round_num = 0;
    endtask

    initial begin
        int          idx;
        logic [15:0] rec;
        string       tag;
        logic        finished;
        rst           = 1'b1;
        left_btn      = 1'b0;
        right_btn     = 1'b0;
        solo_enable   = 1'b0;
        aim           = 2'd0;
        link_rx_valid = 1'b0;
        link_rx_data  = 8'h00;
        lfsr_model    = LFSR_SEED;
        goals         = 0;
        round_num     = 0;
        finished      = 1'b0;
        $readmemh("test/game_stimulus.txt", stim);
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (idx = 0; idx < STIM_DEPTH && !finished; idx++) begin
            rec = stim[idx];
            tag = $sformatf("record %0d", idx);
            if ($isunknown(rec)) begin
                abort_run("The stimulus file ends without an end record.");
            end
            case (rec[15:12])
                4'h0: finished = 1'b1;
                4'h1: press_button(rec[8]);
                4'h2: begin
                    @(posedge clk);
                    solo_enable <= rec[0];
                end
                4'h3: send_peer_byte(rec[7:0]);
                4'h4: expect_tx({tag, " link byte"}, rec[7:0]);
                4'h5: wait_state({tag, " state"}, rec[7:0]);
                4'h6: wait_mode({tag, " mode"}, rec[7:0]);
                4'h7: begin
                    @(negedge clk);
                    check_equal({tag, " score"}, rec[7:0], score_goals);
                end
                4'h8: stay_quiet(tag, rec[7:0]);
                4'h9: play_round(tag, rec[9:8], 1'b1, 2'd0);
                4'ha: play_round(tag, rec[9:8], 1'b0, rec[1:0]);
                4'hb: check_verdict(tag, rec[8]);
                default: abort_run($sformatf("%s: unknown operation %0h.", tag, rec[15:12]));
            endcase
        end

        check_equal("unchecked link bytes", 0, tx_queue.size());
        if (!finished) begin
            abort_run("The stimulus ran past its last record.");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- test/game_stimulus.txt
// One record per 16-bit hex word: op (digit 1), arg (digit 2), value (digits 3 and 4).
// Ops: 1 click (arg 1 right), 2 solo switch, 3 peer byte, 4 tx byte, 5 state, 6 mode,
// 7 score, 8 quiet cycles, 9 solo round (arg aim), a multi round (arg aim, value peer dir),
// b verdict (arg 1 shooter), 0 end.
5000 6001 7000 8014             // Reset: START, MULTI, no tx, no goals.
1000 4000 3000 800a             // Click sends HELLO; peer HELLO connects with no reply.
1000 4060 5001                  // Local start: START_MSG role 1, then keeper.
2001 8005 6001 2000             // Switch flipped mid-match, mode stays MULTI.
a000 a102 a301 a200 a203        // Five rounds against peer choices.
b000 5004 7003                  // Three goals, keeper loses.
1100 5000                       // Right click back to START.
3060 8005 5002                  // Peer START_MSG role 1: shooter, nothing sent.
a002 a101 a200 a300 a103        // Five rounds as shooter.
b100 5003 7003                  // Three goals, shooter wins.
1100 5000
2001 6000 1000 5001             // Solo: keeper against the LFSR.
9000 9100 9200 9300 9200
b000 1100 5000
3060 800a 5000                  // Solo ignores the link.
2000 6001 3060 800a 5000        // Multi again but not connected, so no start.
3000 4000 800a 5000             // Peer HELLO now gets a HELLO reply.
0000

//--- compile.f
verilog/game_pkg.sv
verilog/click_sync.sv
verilog/game_state_sel.sv
verilog/link_ctrl.sv
verilog/solo_opponent.sv
verilog/match_judge.sv
verilog/game_top.sv
test/game_tb.sv

//--- Bender.yml
package:
  name: penalty_game

sources:
  - verilog/game_pkg.sv
  - verilog/click_sync.sv
  - verilog/game_state_sel.sv
  - verilog/link_ctrl.sv
  - verilog/solo_opponent.sv
  - verilog/match_judge.sv
  - verilog/game_top.sv
  - target: test
    files:
      - test/game_tb.sv
